// ==== bench/bus_slave_model.sv ====
`timescale 1ns/100ps

module bus_slave_model import bus_master_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  bus_req,
	input  logic  valid_s,
	input  logic  addr_tx,
	input  logic  data_tx,
	output logic  slave_valid,
	output logic  data_rx,
	// record of the last transfer
	output int    transfers,
	output int    bad_frames,
	output logic  last_write,
	output addr_t last_addr,
	output data_t last_data
);

	// holds written bytes and everything else reads the default
	data_t mem [addr_t];

	function automatic data_t read_byte(addr_t addr);
		if (mem.exists(addr))
			return mem[addr];
		// default is the low address byte with a fixed mask
		return addr[DATA_W-1:0] ^ 8'h5A;
	endfunction

	////////////////////////////////////////
	// read response
	////////////////////////////////////////

	// first bit goes out in the third cycle after the address phase
	task automatic serve_read(data_t rd_byte);
		@(negedge clock);
		@(negedge clock);
		slave_valid = 1'b1;
		// msb first with one cycle per bit
		for (int i = DATA_W - 1; i >= 0; i--)
		begin
			data_rx = rd_byte[i];
			@(negedge clock);
		end
		slave_valid = 1'b0;
		data_rx = 1'b0;
	endtask

	////////////////////////////////////////
	// address phase collection
	////////////////////////////////////////

	task automatic take_transfer();
		addr_t addr;
		data_t data;
		int    slot;
		addr = '0;
		data = '0;
		slot = 0;
		// one slot per cycle while valid_s holds
		while (valid_s && slot <= ADDR_W)
		begin
			addr = {addr[ADDR_W-2:0], addr_tx};
			// data only in the last DATA_W slots
			if (slot >= ADDR_W - DATA_W)
				data = {data[DATA_W-2:0], data_tx};
			// data line stays low before the data slots
			else if (data_tx)
				bad_frames++;
			slot++;
			@(negedge clock);
		end
		if (slot != ADDR_W)
			bad_frames++;
		// a write drops bus_req one cycle after the address phase while a read keeps it
		@(negedge clock);
		transfers++;
		last_addr = addr;
		last_write = !bus_req;
		if (!bus_req)
		begin
			mem[addr] = data;
			last_data = data;
		end
		else
		begin
			last_data = read_byte(addr);
			serve_read(last_data);
		end
	endtask

	// lines change on the falling edge only
	initial
	begin
		slave_valid = 1'b0;
		data_rx = 1'b0;
		transfers = 0;
		bad_frames = 0;
		last_write = 1'b0;
		last_addr = '0;
		last_data = '0;
		forever
		begin
			@(negedge clock);
			if (!reset && valid_s)
				take_transfer();
		end
	end

endmodule

// ==== bench/tb_serial_bus_master.sv ====
`timescale 1ns/100ps

module tb_serial_bus_master import bus_master_pkg::*;
();

	// cycles any single wait may take
	localparam int WAIT_LIMIT = 200;

	// one table row, command plus the byte a read should return
	typedef struct packed {
		master_cmd_t cmd;
		data_t       expect_byte;
	} test_vec_t;

	logic        clock;
	logic        reset;
	master_cmd_t cmd;
	logic        cmd_valid;
	logic        master_busy;
	logic        bus_req;
	logic        bus_ready;
	logic        valid_s;
	logic        addr_tx;
	logic        data_tx;
	logic        slave_valid;
	logic        data_rx;
	data_t       data_read;
	logic        read_done;

	// slave model record
	int          transfers;
	int          bad_frames;
	logic        last_write;
	addr_t       last_addr;
	data_t       last_data;

	test_vec_t   tests[$];
	string       test_names[$];
	int          seed;
	int          errors;
	int          checks;
	logic        grant_seen;

	serial_bus_master #(
		.COUNT_W ($bits(bit_count_t))
	) u_dut (
		.clock       (clock),
		.reset       (reset),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.master_busy (master_busy),
		.bus_req     (bus_req),
		.bus_ready   (bus_ready),
		.valid_s     (valid_s),
		.addr_tx     (addr_tx),
		.data_tx     (data_tx),
		.slave_valid (slave_valid),
		.data_rx     (data_rx),
		.data_read   (data_read),
		.read_done   (read_done)
	);

	bus_slave_model u_slave (
		.clock       (clock),
		.reset       (reset),
		.bus_req     (bus_req),
		.valid_s     (valid_s),
		.addr_tx     (addr_tx),
		.data_tx     (data_tx),
		.slave_valid (slave_valid),
		.data_rx     (data_rx),
		.transfers   (transfers),
		.bad_frames  (bad_frames),
		.last_write  (last_write),
		.last_addr   (last_addr),
		.last_data   (last_data)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock;
	end

	////////////////////////////////////////
	// bus arbiter
	////////////////////////////////////////

	// random grant delay of 0 to 7 cycles, held until the request drops
	initial
	begin
		int delay;
		int held;
		seed = 32'hce7a_89bb;
		bus_ready = 1'b0;
		forever
		begin
			@(negedge clock);
			if (bus_req && !reset)
			begin
				delay = $random(seed) & 7;
				repeat (delay)
					@(negedge clock);
				bus_ready = 1'b1;
				held = 0;
				while (bus_req && held < WAIT_LIMIT)
				begin
					@(negedge clock);
					held++;
				end
				bus_ready = 1'b0;
			end
		end
	end

	// valid_s only after the grant of the current request
	always @(posedge clock)
	begin
		if (reset)
			grant_seen = 1'b0;
		else
		begin
			if (valid_s)
			begin
				assert (grant_seen)
				else
				begin
					$display("error: valid_s was high before bus_ready was granted");
					errors++;
				end
			end
			if (!bus_req)
				grant_seen = 1'b0;
			else if (bus_ready)
				grant_seen = 1'b1;
		end
	end

	////////////////////////////////////////
	// checks and waits
	////////////////////////////////////////

	task automatic check_equal(string test, string field, logic [31:0] expected,
		logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
			errors++;
		end
	endtask

	task automatic check_true(logic cond, string what);
		checks++;
		assert (cond)
		else
		begin
			$display("error: %s", what);
			errors++;
		end
	endtask

	task automatic wait_idle(string test);
		int n;
		n = 0;
		while (master_busy && n < WAIT_LIMIT)
		begin
			@(negedge clock);
			n++;
		end
		check_true(!master_busy, {"master_busy never fell in ", test});
	endtask

	// read_done is a single cycle pulse, polled on every falling edge
	task automatic wait_read(string test, data_t expect_byte);
		int n;
		n = 0;
		while (!read_done && n < WAIT_LIMIT)
		begin
			@(negedge clock);
			n++;
		end
		check_true(read_done, {"no read_done pulse in ", test});
		if (read_done)
			check_equal(test, "data_read", 32'(expect_byte), 32'(data_read));
	endtask

	task automatic add_test(string name, logic read, addr_t addr, data_t data,
		data_t expect_byte);
		test_vec_t tv;
		tv.cmd.read = read;
		tv.cmd.addr = addr;
		tv.cmd.data = data;
		tv.expect_byte = expect_byte;
		tests.push_back(tv);
		test_names.push_back(name);
	endtask

	task automatic run_test(string test, test_vec_t tv, int done_count);
		// one cycle of cmd_valid while idle
		cmd = tv.cmd;
		cmd_valid = 1'b1;
		@(negedge clock);
		cmd_valid = 1'b0;
		check_true(master_busy, {"command was not accepted in ", test});
		// second command while busy, must be dropped
		cmd = ~tv.cmd;
		cmd_valid = 1'b1;
		@(negedge clock);
		cmd_valid = 1'b0;
		cmd = '0;
		if (tv.cmd.read)
			wait_read(test, tv.expect_byte);
		wait_idle(test);
		// slave record settles one edge after busy drops
		@(negedge clock);
		check_equal(test, "transfers", 32'(done_count), 32'(transfers));
		check_equal(test, "slave addr", 32'(tv.cmd.addr), 32'(last_addr));
		check_equal(test, "slave write", 32'(!tv.cmd.read), 32'(last_write));
		if (!tv.cmd.read)
			check_equal(test, "slave data", 32'(tv.cmd.data), 32'(last_data));
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		errors = 0;
		checks = 0;
		reset = 1'b1;
		cmd = '0;
		cmd_valid = 1'b0;

		//       name          read  addr      data   expected
		add_test("wr_first",   1'b0, 14'h0123, 8'hA5, 8'h00);
		add_test("rd_first",   1'b1, 14'h0123, 8'h00, 8'hA5);
		add_test("rd_default", 1'b1, 14'h2A7C, 8'h00, 8'h26);
		add_test("wr_top",     1'b0, 14'h3FFF, 8'h3C, 8'h00);
		add_test("wr_zero",    1'b0, 14'h0000, 8'hFF, 8'h00);
		add_test("rd_top",     1'b1, 14'h3FFF, 8'h00, 8'h3C);
		add_test("rd_zero",    1'b1, 14'h0000, 8'h00, 8'hFF);
		add_test("rd_default2", 1'b1, 14'h1A81, 8'h00, 8'hDB);

		repeat (4)
			@(negedge clock);
		reset = 1'b0;
		// every output at its idle value
		check_equal("reset", "idle lines", 32'd0,
			32'({bus_req, valid_s, master_busy, read_done, addr_tx, data_tx}));
		check_equal("reset", "data_read", 32'd0, 32'(data_read));

		for (int i = 0; i < tests.size(); i++)
			run_test(test_names[i], tests[i], i + 1);
		check_equal("summary", "bad frames", 32'd0, 32'(bad_frames));

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== list.f ====
src/bus_master_pkg.sv
src/bit_counter.sv
src/tx_shifter.sv
src/rx_shifter.sv
src/master_fsm.sv
src/serial_bus_master.sv
bench/bus_slave_model.sv
bench/tb_serial_bus_master.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the serial bus master testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_serial_bus_master
LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" -Mdir obj_dir -f list.f; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/V"$TOP" 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
exit 0

// ==== src/bit_counter.sv ====
`timescale 1ns/100ps

module bit_counter import bus_master_pkg::*;
#(
	parameter int COUNT_W = $bits(bit_count_t)
)
(
	input  logic               clock,
	input  logic               reset,
	input  logic               clear,
	input  logic               enable,
	output logic [COUNT_W-1:0] count
);

	// clear wins over enable
	always_ff @(posedge clock)
	begin
		if (reset)
			count <= '0;
		else if (clear)
			count <= '0;
		else if (enable)
			count <= count + 1'b1;
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// address phase is the longest run of slots
	a_count_limit: assert property (
		@(posedge clock) disable iff (reset)
		(enable && !clear) |=> (count <= COUNT_W'(ADDR_W))
	)
	else
		$error("bit_counter stepped past the address length");

endmodule

// ==== src/bus_master_pkg.sv ====
package bus_master_pkg;

	////////////////////////////////////////
	// serial field widths
	////////////////////////////////////////

	// address goes out first, msb leading
	localparam int ADDR_W = 14;
	// one data byte per transfer
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// slot index, must reach ADDR_W
	typedef logic [4:0] bit_count_t;

	// user command as presented at the top
	typedef struct packed {
		logic  read;
		addr_t addr;
		data_t data;
	} master_cmd_t;

	// transfer sequence of the master
	typedef enum logic [2:0] {
		IDLE,
		REQUEST,
		ADDRESS,
		WAIT_SLAVE,
		RECEIVE,
		FINISH
	} master_state_t;

endpackage

// ==== src/master_fsm.sv ====
`timescale 1ns/100ps

module master_fsm import bus_master_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       cmd_valid,
	input  logic       read_cmd,
	input  logic       bus_ready,
	input  logic       slave_valid,
	input  bit_count_t count,
	output logic       count_clear,
	output logic       count_enable,
	output logic       load,
	output logic       shift_enable,
	output logic       sample_enable,
	output logic       capture,
	output logic       bus_req,
	output logic       valid_s,
	output logic       master_busy
);

	// phase lengths in counter slots
	localparam bit_count_t ADDR_SLOTS = bit_count_t'(ADDR_W);
	localparam bit_count_t DATA_SLOTS = bit_count_t'(DATA_W);

	master_state_t state;
	master_state_t state_next;
	logic          accept;
	logic          addr_last;

	// busy is registered, so a command while busy drops out here
	assign accept = (state == IDLE) && cmd_valid && !master_busy;
	// all address bits have been sent
	assign addr_last = (state == ADDRESS) && (count == ADDR_SLOTS);

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
				if (accept)
					state_next = REQUEST;
			// wait for the grant without a time limit
			REQUEST:
				if (bus_ready)
					state_next = ADDRESS;
			ADDRESS:
				if (addr_last)
					state_next = read_cmd ? WAIT_SLAVE : FINISH;
			// slave marks its first data bit with slave_valid
			WAIT_SLAVE:
				if (slave_valid)
					state_next = RECEIVE;
			RECEIVE:
				if (count == DATA_SLOTS)
					state_next = FINISH;
			FINISH:
				state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	////////////////////////////////////////
	// datapath steering
	////////////////////////////////////////

	always_comb
	begin
		load = accept;
		// grant edge already puts out slot 0
		shift_enable = ((state == REQUEST) && bus_ready) ||
			((state == ADDRESS) && (count < ADDR_SLOTS));
		// bit 7 on the slave_valid edge and the rest by slot
		sample_enable = ((state == WAIT_SLAVE) && slave_valid) ||
			((state == RECEIVE) && (count < DATA_SLOTS));
		capture = (state == RECEIVE) && (count == DATA_SLOTS);
		// counter restarts for the receive phase
		count_clear = accept || addr_last;
		count_enable = shift_enable || sample_enable;
	end

	// outputs follow the state being entered
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= IDLE;
			bus_req <= 1'b0;
			master_busy <= 1'b0;
			valid_s <= 1'b0;
		end
		else
		begin
			state <= state_next;
			bus_req <= (state_next != IDLE);
			master_busy <= (state_next != IDLE);
			valid_s <= (state_next == ADDRESS);
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// address phase only after a seen grant
	a_grant_first: assert property (
		@(posedge clock) disable iff (reset)
		$rose(valid_s) |-> $past(bus_ready) && $past(bus_req)
	)
	else
		$error("valid_s rose without a bus grant");

	// no restart on a lost grant
	a_grant_held: assert property (
		@(posedge clock) disable iff (reset)
		valid_s |-> bus_ready
	)
	else
		$error("bus_ready dropped during the address phase");

endmodule

// ==== src/rx_shifter.sv ====
`timescale 1ns/100ps

module rx_shifter import bus_master_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  sample_enable,
	input  logic  data_rx,
	input  logic  capture,
	output data_t data_read,
	output logic  read_done
);

	data_t rx_sr;

	// msb arrives first, so shift toward the msb
	always_ff @(posedge clock)
	begin
		if (sample_enable)
			rx_sr <= {rx_sr[DATA_W-2:0], data_rx};
	end

	////////////////////////////////////////
	// publish the byte
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			data_read <= '0;
			read_done <= 1'b0;
		end
		else
		begin
			// single cycle pulse with the new byte
			read_done <= capture;
			if (capture)
				data_read <= rx_sr;
		end
	end

endmodule

// ==== src/serial_bus_master.sv ====
`timescale 1ns/100ps

module serial_bus_master import bus_master_pkg::*;
#(
	parameter int COUNT_W = $bits(bit_count_t)
)
(
	input  logic        clock,
	input  logic        reset,
	// user side
	input  master_cmd_t cmd,
	input  logic        cmd_valid,
	output logic        master_busy,
	// arbiter
	output logic        bus_req,
	input  logic        bus_ready,
	// serial lines to the slave
	output logic        valid_s,
	output logic        addr_tx,
	output logic        data_tx,
	input  logic        slave_valid,
	input  logic        data_rx,
	// read result
	output data_t       data_read,
	output logic        read_done
);

	bit_count_t count;
	logic       count_clear;
	logic       count_enable;
	logic       load;
	logic       shift_enable;
	logic       sample_enable;
	logic       capture;
	logic       read_cmd;

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	master_fsm u_fsm (
		.clock         (clock),
		.reset         (reset),
		.cmd_valid     (cmd_valid),
		.read_cmd      (read_cmd),
		.bus_ready     (bus_ready),
		.slave_valid   (slave_valid),
		.count         (count),
		.count_clear   (count_clear),
		.count_enable  (count_enable),
		.load          (load),
		.shift_enable  (shift_enable),
		.sample_enable (sample_enable),
		.capture       (capture),
		.bus_req       (bus_req),
		.valid_s       (valid_s),
		.master_busy   (master_busy)
	);

	// slot counter shared by both phases
	bit_counter #(
		.COUNT_W (COUNT_W)
	) u_counter (
		.clock  (clock),
		.reset  (reset),
		.clear  (count_clear),
		.enable (count_enable),
		.count  (count)
	);

	////////////////////////////////////////
	// serial datapath
	////////////////////////////////////////

	tx_shifter u_tx (
		.clock        (clock),
		.reset        (reset),
		.load         (load),
		.cmd_in       (cmd),
		.shift_enable (shift_enable),
		.count        (count),
		.read_cmd     (read_cmd),
		.addr_tx      (addr_tx),
		.data_tx      (data_tx)
	);

	rx_shifter u_rx (
		.clock         (clock),
		.reset         (reset),
		.sample_enable (sample_enable),
		.data_rx       (data_rx),
		.capture       (capture),
		.data_read     (data_read),
		.read_done     (read_done)
	);

endmodule

// ==== src/tx_shifter.sv ====
`timescale 1ns/100ps

module tx_shifter import bus_master_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        load,
	input  master_cmd_t cmd_in,
	input  logic        shift_enable,
	input  bit_count_t  count,
	output logic        read_cmd,
	output logic        addr_tx,
	output logic        data_tx
);

	// first address slot that also carries data
	localparam bit_count_t DATA_START = bit_count_t'(ADDR_W - DATA_W);

	addr_t addr_sr;
	data_t data_sr;
	logic  data_slot;

	// data rides with the last DATA_W address bits, writes only
	assign data_slot = (count >= DATA_START) && !read_cmd;

	////////////////////////////////////////
	// command capture and shift registers
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (load)
		begin
			addr_sr <= cmd_in.addr;
			data_sr <= cmd_in.data;
		end
		else if (shift_enable)
		begin
			addr_sr <= addr_sr << 1;
			// data register only moves in its own slots
			if (data_slot)
				data_sr <= data_sr << 1;
		end
	end

	// read flag steers the fsm after the address phase
	always_ff @(posedge clock)
	begin
		if (reset)
			read_cmd <= 1'b0;
		else if (load)
			read_cmd <= cmd_in.read;
	end

	// serial lines idle low outside an active slot
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			addr_tx <= 1'b0;
			data_tx <= 1'b0;
		end
		else
		begin
			addr_tx <= shift_enable && addr_sr[ADDR_W-1];
			data_tx <= shift_enable && data_slot && data_sr[DATA_W-1];
		end
	end

	// a new command never lands mid shift
	a_load_vs_shift: assert property (
		@(posedge clock) disable iff (reset)
		!(load && shift_enable)
	)
	else
		$error("tx_shifter load collided with shift_enable");

endmodule
